// ==== common/move_order_pkg.sv ====
package move_order_pkg;

    // largest batch the sorter can hold
    localparam int MAX_MOVES = 63;

    // depth slots in the move stack
    localparam int MAX_DEPTH = 32;

    // moves per depth slot in the stack RAM, one more than a full batch
    localparam int SLOT_MOVES = 64;
    localparam int STACK_WORDS = MAX_DEPTH * SLOT_MOVES;

    // src square, dst square, flags; the design never looks inside
    typedef struct packed {
        logic [5:0] src;
        logic [5:0] dst;
        logic [3:0] flags;
    } move_t;

    typedef logic signed [15:0] eval_t;

    // eval with the sign bit flipped, so an unsigned compare orders like a signed one
    typedef logic [15:0] sort_key_t;

    // position inside a batch
    typedef logic [5:0] move_idx_t;

    // batch length, 0 to MAX_MOVES
    typedef logic [6:0] move_len_t;

    typedef logic [4:0] depth_t;

    // {depth, move index}
    typedef logic [10:0] stack_addr_t;

    typedef enum logic [1:0] {
        BS_IDLE,
        BS_FILL,
        BS_FLUSH,
        BS_DRAIN
    } batch_state_t;

endpackage

// ==== common/sort_entry_if.sv ====
`timescale 1ns/10ps

interface sort_entry_if;
    import move_order_pkg::*;

    logic      valid;
    logic      clear;
    move_t     move;
    sort_key_t key;

    modport intake (
        output valid,
        output clear,
        output move,
        output key
    );

    modport sorter (
        input valid,
        input clear,
        input move,
        input key
    );
endinterface

// ==== common/drain_if.sv ====
`timescale 1ns/10ps

interface drain_if;
    import move_order_pkg::*;

    move_t     top_move;
    move_len_t len;
    logic      dequeue;
    depth_t    depth;

    modport sorter (
        output top_move,
        output len,
        input  dequeue
    );

    modport control (
        input  len,
        output dequeue,
        output depth
    );

    modport stack (
        input top_move,
        input dequeue,
        input depth
    );
endinterface

// ==== rtl/batch_intake.sv ====
`timescale 1ns/10ps

module batch_intake (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      batch_start,
    input  move_order_pkg::depth_t    batch_depth,
    input  logic                      move_valid,
    input  move_order_pkg::move_t     move_in,
    input  move_order_pkg::eval_t     eval_in,
    input  logic                      batch_end,
    output logic                      ready,
    output logic                      batch_done,
    output move_order_pkg::move_len_t num_moves,
    sort_entry_if.intake              entry,
    drain_if.control                  drain
);
    import move_order_pkg::*;

    batch_state_t state;

    logic      clear_q;
    logic      valid_q;
    move_t     move_q;
    sort_key_t key_q;
    depth_t    depth_q;
    move_len_t drain_cnt;
    move_len_t final_len;

    assign ready = (state == BS_IDLE);

    assign entry.clear = clear_q;
    assign entry.valid = valid_q;
    assign entry.move  = move_q;
    assign entry.key   = key_q;

    assign drain.dequeue = (state == BS_DRAIN);
    assign drain.depth   = depth_q;

    // length once the entry still in the register has been inserted
    always_comb begin
        final_len = drain.len;
        if (valid_q && drain.len != move_len_t'(MAX_MOVES)) begin
            final_len = drain.len + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= BS_IDLE;
            clear_q    <= 1'b0;
            valid_q    <= 1'b0;
            batch_done <= 1'b0;
            drain_cnt  <= '0;
            num_moves  <= '0;
        end else begin
            clear_q    <= 1'b0;
            valid_q    <= 1'b0;
            batch_done <= 1'b0;
            case (state)
                BS_IDLE: begin
                    if (batch_start) begin
                        clear_q <= 1'b1;
                        state   <= BS_FILL;
                    end
                end
                BS_FILL: begin
                    valid_q <= move_valid;
                    if (batch_end) begin
                        state <= BS_FLUSH;
                    end
                end
                BS_FLUSH: begin
                    drain_cnt <= '0;
                    num_moves <= final_len;
                    if (final_len == '0) begin
                        batch_done <= 1'b1;
                        state      <= BS_IDLE;
                    end else begin
                        state <= BS_DRAIN;
                    end
                end
                BS_DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    // last dequeue this cycle
                    if (drain_cnt == num_moves - 1'b1) begin
                        batch_done <= 1'b1;
                        state      <= BS_IDLE;
                    end
                end
                default: state <= BS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == BS_IDLE && batch_start) begin
            depth_q <= batch_depth;
        end
        if (move_valid) begin
            move_q <= move_in;
            key_q  <= {~eval_in[$bits(eval_t) - 1], eval_in[$bits(eval_t) - 2:0]};
        end
    end
endmodule

// ==== stream_sorter/stream_sorter.sv ====
`timescale 1ns/10ps

module stream_sorter (
    input  logic         clk_in,
    input  logic         rst_in,
    sort_entry_if.sorter entry,
    drain_if.sorter      drain
);
    import move_order_pkg::*;

    move_t     moves [MAX_MOVES];
    sort_key_t keys  [MAX_MOVES];
    move_len_t len;

    // ge[i]: slot i is occupied and stays ahead of the new entry
    logic [MAX_MOVES - 1:0] ge;
    logic                   full;
    logic                   do_insert;

    assign full      = (len == move_len_t'(MAX_MOVES));
    assign do_insert = entry.valid && !full;

    assign drain.top_move = moves[0];
    assign drain.len      = len;

    always_comb begin
        for (int i = 0; i < MAX_MOVES; i++) begin
            // equal keys stay ahead, so ties keep arrival order
            ge[i] = (i < len) && (keys[i] >= entry.key);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            len <= '0;
        end else if (entry.clear) begin
            len <= '0;
        end else if (drain.dequeue) begin
            if (len != '0) begin
                len <= len - 1'b1;
            end
        end else if (do_insert) begin
            len <= len + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (drain.dequeue) begin
            for (int i = 0; i < MAX_MOVES - 1; i++) begin
                moves[i] <= moves[i + 1];
                keys[i]  <= keys[i + 1];
            end
        end else if (do_insert) begin
            if (!ge[0]) begin
                moves[0] <= entry.move;
                keys[0]  <= entry.key;
            end
            for (int i = 1; i < MAX_MOVES; i++) begin
                if (ge[i - 1] && !ge[i]) begin
                    moves[i] <= entry.move;
                    keys[i]  <= entry.key;
                end else if (!ge[i]) begin
                    // strictly lower keys move one slot down
                    moves[i] <= moves[i - 1];
                    keys[i]  <= keys[i - 1];
                end
            end
        end
    end
endmodule

// ==== rtl/move_stack.sv ====
`timescale 1ns/10ps

module move_stack (
    input  logic                      clk_in,
    input  logic                      rst_in,
    drain_if.stack                    drain,
    input  logic                      read_en,
    input  move_order_pkg::depth_t    read_depth,
    input  move_order_pkg::move_idx_t read_idx,
    output logic                      read_valid,
    output move_order_pkg::move_t     read_move
);
    import move_order_pkg::*;

    move_t mem [STACK_WORDS];

    move_idx_t   wr_idx;
    stack_addr_t wr_addr;
    stack_addr_t rd_addr;
    move_t       rd_data;
    logic        rd_valid;

    assign wr_addr = {drain.depth, wr_idx};
    assign rd_addr = {read_depth, read_idx};

    // write index follows the dequeue run and restarts between batches
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_idx <= '0;
        end else if (drain.dequeue) begin
            wr_idx <= wr_idx + 1'b1;
        end else begin
            wr_idx <= '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (drain.dequeue) begin
            mem[wr_addr] <= drain.top_move;
        end
    end

    // two register stages on the read side
    always_ff @(posedge clk_in) begin
        if (read_en) begin
            rd_data <= mem[rd_addr];
        end
        read_move <= rd_data;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_valid   <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            rd_valid   <= read_en;
            read_valid <= rd_valid;
        end
    end
endmodule

// ==== rtl/move_order_top.sv ====
`timescale 1ns/10ps

module move_order_top (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      batch_start,
    input  move_order_pkg::depth_t    batch_depth,
    input  logic                      move_valid,
    input  move_order_pkg::move_t     move_in,
    input  move_order_pkg::eval_t     eval_in,
    input  logic                      batch_end,
    output logic                      ready,
    output logic                      batch_done,
    output move_order_pkg::move_len_t num_moves,
    input  logic                      read_en,
    input  move_order_pkg::depth_t    read_depth,
    input  move_order_pkg::move_idx_t read_idx,
    output logic                      read_valid,
    output move_order_pkg::move_t     read_move
);

    sort_entry_if entry_bus ();
    drain_if      drain_bus ();

    // batch control and entry register
    batch_intake intake0 (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .batch_start (batch_start),
        .batch_depth (batch_depth),
        .move_valid  (move_valid),
        .move_in     (move_in),
        .eval_in     (eval_in),
        .batch_end   (batch_end),
        .ready       (ready),
        .batch_done  (batch_done),
        .num_moves   (num_moves),
        .entry       (entry_bus.intake),
        .drain       (drain_bus.control)
    );

    stream_sorter sorter0 (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .entry  (entry_bus.sorter),
        .drain  (drain_bus.sorter)
    );

    // drained batches land here, read back by depth and index
    move_stack stack0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .drain      (drain_bus.stack),
        .read_en    (read_en),
        .read_depth (read_depth),
        .read_idx   (read_idx),
        .read_valid (read_valid),
        .read_move  (read_move)
    );
endmodule

// ==== verification/move_order_sva.sv ====
`timescale 1ns/10ps

module move_order_sva (
    input logic                      clk_in,
    input logic                      rst_in,
    input move_order_pkg::move_len_t len,
    input logic                      dequeue,
    input logic                      strobe
);
    import move_order_pkg::*;

    a_len_max: assert property (@(posedge clk_in) disable iff (rst_in)
        len <= move_len_t'(MAX_MOVES))
        else $error("sorter length above MAX_MOVES");

    a_no_empty_dequeue: assert property (@(posedge clk_in) disable iff (rst_in)
        dequeue |-> len != '0)
        else $error("dequeue while the sorter is empty");

    // clear on the sorter side, batch_done on the controller side
    a_single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        strobe |=> !strobe)
        else $error("pulse held longer than one cycle");
endmodule

bind stream_sorter move_order_sva sorter_sva0 (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .len     (len),
    .dequeue (drain.dequeue),
    .strobe  (entry.clear)
);

bind batch_intake move_order_sva intake_sva0 (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .len     (drain.len),
    .dequeue (drain.dequeue),
    .strobe  (batch_done)
);

// ==== verification/move_order_tb.sv ====
`timescale 1ns/10ps

module move_order_tb;
    import move_order_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_BATCHES     = 5;
    localparam int TOTAL_ENTRIES   = 86;
    localparam int PER_MOVE_CYCLES = 16;
    localparam int BATCH_CYCLES    = 32;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + TOTAL_ENTRIES * PER_MOVE_CYCLES
                                      + NUM_BATCHES * BATCH_CYCLES) * CLK_PERIOD;

    logic      clk_in;
    logic      rst_in;
    logic      batch_start;
    depth_t    batch_depth;
    logic      move_valid;
    move_t     move_in;
    eval_t     eval_in;
    logic      batch_end;
    logic      ready;
    logic      batch_done;
    move_len_t num_moves;
    logic      read_en;
    depth_t    read_depth;
    move_idx_t read_idx;
    logic      read_valid;
    move_t     read_move;

    integer seed;

    // one row per batch with its entries stored flat from tab_first onwards
    depth_t tab_depth [NUM_BATCHES];
    int     tab_len   [NUM_BATCHES];
    int     tab_first [NUM_BATCHES];
    move_t  tab_move  [TOTAL_ENTRIES];
    eval_t  tab_eval  [TOTAL_ENTRIES];
    move_t  exp_move  [TOTAL_ENTRIES];

    move_order_top dut0 (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .batch_start (batch_start),
        .batch_depth (batch_depth),
        .move_valid  (move_valid),
        .move_in     (move_in),
        .eval_in     (eval_in),
        .batch_end   (batch_end),
        .ready       (ready),
        .batch_done  (batch_done),
        .num_moves   (num_moves),
        .read_en     (read_en),
        .read_depth  (read_depth),
        .read_idx    (read_idx),
        .read_valid  (read_valid),
        .read_move   (read_move)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_move(string name, move_t got, move_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(string name, move_len_t got, move_len_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic build_table();
        int n;
        int tie_evals [6] = '{5, 5, -3, 5, -3, 100};
        int edge_evals [5] = '{0, -32768, 32767, 1, -1};
        tab_depth = '{5'd3, 5'd7, 5'd12, 5'd20, 5'd9};
        tab_len   = '{12, 6, 5, 63, 0};
        n = 0;
        for (int b = 0; b < NUM_BATCHES; b++) begin
            tab_first[b] = n;
            n += tab_len[b];
            for (int k = 0; k < tab_len[b]; k++) begin
                tab_move[tab_first[b] + k] = {6'(k), 6'(tab_depth[b]), 4'(b)};
                tab_eval[tab_first[b] + k] = eval_t'($random(seed));
            end
        end
        // batch 1 carries ties and batch 2 the sign edges
        for (int k = 0; k < 6; k++) begin
            tab_eval[tab_first[1] + k] = eval_t'(tie_evals[k]);
        end
        for (int k = 0; k < 5; k++) begin
            tab_eval[tab_first[2] + k] = eval_t'(edge_evals[k]);
        end
    endtask

    // stable insertion sort with the highest evaluation first
    task automatic sort_reference(int b);
        int    first;
        int    j;
        move_t m;
        eval_t e;
        eval_t sort_eval [MAX_MOVES];
        first = tab_first[b];
        for (int k = 0; k < tab_len[b]; k++) begin
            exp_move[first + k] = tab_move[first + k];
            sort_eval[k] = tab_eval[first + k];
        end
        for (int i = 1; i < tab_len[b]; i++) begin
            m = exp_move[first + i];
            e = sort_eval[i];
            j = i - 1;
            while (j >= 0 && sort_eval[j] < e) begin
                sort_eval[j + 1] = sort_eval[j];
                exp_move[first + j + 1] = exp_move[first + j];
                j--;
            end
            sort_eval[j + 1] = e;
            exp_move[first + j + 1] = m;
        end
    endtask

    task automatic run_batch(int b);
        int first;
        int len;
        int waited;
        first = tab_first[b];
        len = tab_len[b];
        @(negedge clk_in);
        check_bit("ready", ready, 1'b1);
        batch_start = 1'b1;
        batch_depth = tab_depth[b];
        @(negedge clk_in);
        batch_start = 1'b0;
        // the depth is latched at the start, later changes must not reach the stack
        batch_depth = ~tab_depth[b];
        check_bit("ready", ready, 1'b0);
        // batch_end goes out with the last move
        for (int k = 0; k < len; k++) begin
            move_valid = 1'b1;
            move_in = tab_move[first + k];
            eval_in = tab_eval[first + k];
            batch_end = (k == len - 1);
            @(negedge clk_in);
        end
        if (len == 0) begin
            batch_end = 1'b1;
            @(negedge clk_in);
        end
        move_valid = 1'b0;
        batch_end = 1'b0;
        waited = 0;
        while (batch_done !== 1'b1) begin
            if (waited > MAX_MOVES + 8) begin
                fail_run($sformatf("batch_done never arrived for batch %0d", b));
            end else begin
                @(negedge clk_in);
                waited++;
            end
        end
        check_len("num_moves", num_moves, move_len_t'(len));
        check_bit("ready", ready, 1'b1);
    endtask

    // one read per cycle and each result checked two cycles after its request
    task automatic read_batch(int b);
        int first;
        int len;
        first = tab_first[b];
        len = tab_len[b];
        for (int k = 0; k < len + 2; k++) begin
            @(negedge clk_in);
            if (k >= 2) begin
                if (read_valid !== 1'b1) begin
                    fail_run($sformatf("read_valid missing for depth %0d index %0d",
                                       tab_depth[b], k - 2));
                end else begin
                    check_move("read_move", read_move, exp_move[first + k - 2]);
                end
            end
            read_en = (k < len);
            read_depth = tab_depth[b];
            read_idx = move_idx_t'(k);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all batches were checked");
    end

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        batch_start = 1'b0;
        batch_depth = '0;
        move_valid = 1'b0;
        move_in = '0;
        eval_in = '0;
        batch_end = 1'b0;
        read_en = 1'b0;
        read_depth = '0;
        read_idx = '0;
        seed = 32'h84d28909;
        build_table();
        for (int b = 0; b < NUM_BATCHES; b++) begin
            sort_reference(b);
        end
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        check_bit("ready", ready, 1'b1);
        check_bit("batch_done", batch_done, 1'b0);
        check_bit("read_valid", read_valid, 1'b0);
        for (int b = 0; b < NUM_BATCHES; b++) begin
            run_batch(b);
            read_batch(b);
        end
        // earlier depths must be untouched by the later batches
        for (int b = 0; b < NUM_BATCHES; b++) begin
            read_batch(b);
        end
        $display("TEST PASS");
        $finish;
    end
endmodule

// ==== filelist.f ====
common/move_order_pkg.sv
common/sort_entry_if.sv
common/drain_if.sv
rtl/batch_intake.sv
stream_sorter/stream_sorter.sv
rtl/move_stack.sv
rtl/move_order_top.sv
verification/move_order_sva.sv
verification/move_order_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the move ordering testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module move_order_tb --Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmove_order_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
